// File: hw/cache_pkg.sv
package cache_pkg;

    // four ways per set
    localparam int NUM_WAYS = 4;

    // way index
    typedef logic [1:0] way_t;

    // tree bits for one set
    // bit 2: half used last, 0 for ways 0-1, 1 for ways 2-3
    // bit 1: way used last within ways 0-1
    // bit 0: way used last within ways 2-3
    typedef logic [2:0] plru_t;

    // source of a data array write
    typedef enum logic [1:0] {
        WR_NONE = 2'd0,
        WR_CPU  = 2'd1,
        WR_MEM  = 2'd2
    } wr_src_t;

endpackage : cache_pkg

// File: hw/cache_lookup_if.sv
`timescale 1ns/10ps

interface cache_lookup_if #(
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32
);
    import cache_pkg::*;

    // lookup results from the arrays
    logic                  hit;
    way_t                  hit_way;
    logic [DATA_W-1:0]     hit_data;
    logic [NUM_WAYS-1:0]   valid;

    // victim line as seen by the arrays
    logic                  victim_dirty;
    logic [ADDR_W-1:0]     victim_addr;
    logic [DATA_W-1:0]     victim_data;

    // replacement choice
    way_t                  victim_way;

    // controller strobes
    wr_src_t               wr_src;
    way_t                  wr_way;
    logic                  fill;
    logic                  inval;
    logic                  plru_upd;

    modport ctrl (
        input  hit, hit_way, victim_dirty, victim_way,
        output wr_src, wr_way, fill, inval, plru_upd
    );

    modport arrays (
        input  wr_src, wr_way, fill, inval, victim_way,
        output hit, hit_way, hit_data, valid, victim_dirty, victim_addr, victim_data
    );

    modport repl (
        input  valid, hit_way, plru_upd,
        output victim_way
    );

endinterface : cache_lookup_if

// File: hw/cache_ewb_if.sv
`timescale 1ns/10ps

interface cache_ewb_if;

    // controller side
    // push victim into the buffer
    logic load;
    // entry written back, release it
    logic deq;

    // buffer side
    logic full;
    // request address hits the held entry
    logic match;

    modport ctrl (
        input  full, match,
        output load, deq
    );

    modport buffer (
        input  load, deq,
        output full, match
    );

endinterface : cache_ewb_if

// File: hw/cache_arrays.sv
`timescale 1ns/10ps

module cache_arrays #(
    parameter int ADDR_W   = 16,
    parameter int DATA_W   = 32,
    parameter int SET_BITS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ADDR_W-1:0]   addr,
    input  logic [DATA_W-1:0]   wdata,
    input  logic [DATA_W-1:0]   fill_data,
    cache_lookup_if.arrays      lk
);
    import cache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int TAG_W    = ADDR_W - SET_BITS;

    // storage per set and way
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0]   data_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_r  [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_r  [NUM_SETS];

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_W-1:0]    tag;
    logic [NUM_WAYS-1:0] way_hit;

    // address split, no word offset
    assign set_idx = addr[SET_BITS-1:0];
    assign tag     = addr[ADDR_W-1:SET_BITS];

    // compare all four ways at once
    always_comb
    begin
        way_hit = '0;
        lk.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = valid_r[set_idx][w] && (tag_mem[set_idx][w] == tag);
            if (way_hit[w])
                lk.hit_way = way_t'(w);
        end
    end

    assign lk.hit      = |way_hit;
    assign lk.hit_data = data_mem[set_idx][lk.hit_way];
    assign lk.valid    = valid_r[set_idx];

    // victim line, only dirty if still valid
    assign lk.victim_dirty = valid_r[set_idx][lk.victim_way] && dirty_r[set_idx][lk.victim_way];
    assign lk.victim_addr  = {tag_mem[set_idx][lk.victim_way], set_idx};
    assign lk.victim_data  = data_mem[set_idx][lk.victim_way];

    // tag and data, no reset
    always_ff @(posedge clk)
    begin
        if (lk.fill)
            tag_mem[set_idx][lk.wr_way] <= tag;
        if (lk.wr_src == WR_CPU)
            data_mem[set_idx][lk.wr_way] <= wdata;
        else if (lk.wr_src == WR_MEM)
            data_mem[set_idx][lk.wr_way] <= fill_data;
    end

    // valid and dirty state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
            end
        end
        else
        begin
            if (lk.fill)
            begin
                valid_r[set_idx][lk.wr_way] <= 1'b1;
                dirty_r[set_idx][lk.wr_way] <= 1'b0;
            end
            else if (lk.inval)
            begin
                valid_r[set_idx][lk.wr_way] <= 1'b0;
                dirty_r[set_idx][lk.wr_way] <= 1'b0;
            end
            else if (lk.wr_src == WR_CPU)
                dirty_r[set_idx][lk.wr_way] <= 1'b1;
        end
    end

    // a fill only ever targets a missing tag, so at most one way matches
    assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule : cache_arrays

// File: hw/plru_tree.sv
`timescale 1ns/10ps

module plru_tree #(
    parameter int SET_BITS = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] set_idx,
    cache_lookup_if.repl        lk
);
    import cache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;

    plru_t plru_r [NUM_SETS];
    plru_t cur;
    plru_t nxt;

    assign cur = plru_r[set_idx];

    // new tree bits after a use of the hit way
    always_comb
    begin
        case (lk.hit_way)
            2'd0:    nxt = {1'b0, 1'b0, cur[0]};
            2'd1:    nxt = {1'b0, 1'b1, cur[0]};
            2'd2:    nxt = {1'b1, cur[1], 1'b0};
            default: nxt = {1'b1, cur[1], 1'b1};
        endcase
    end

    // victim choice
    always_comb
    begin
        if (!lk.valid[0])
            lk.victim_way = 2'd0;
        else if (!lk.valid[1])
            lk.victim_way = 2'd1;
        else if (!lk.valid[2])
            lk.victim_way = 2'd2;
        else if (!lk.valid[3])
            lk.victim_way = 2'd3;
        // ways 0-1 used last, pick from 2-3
        else if (!cur[2])
            lk.victim_way = cur[0] ? 2'd2 : 2'd3;
        // ways 2-3 used last, pick from 0-1
        else
            lk.victim_way = cur[1] ? 2'd0 : 2'd1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                plru_r[s] <= '0;
        end
        else if (lk.plru_upd)
            plru_r[set_idx] <= nxt;
    end

endmodule : plru_tree

// File: hw/eviction_buffer.sv
`timescale 1ns/10ps

module eviction_buffer #(
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    cache_ewb_if.buffer         ewb,
    input  logic [ADDR_W-1:0]   victim_addr,
    input  logic [DATA_W-1:0]   victim_data,
    input  logic [ADDR_W-1:0]   req_addr,
    input  logic [DATA_W-1:0]   wdata,
    input  logic                mem_write,
    output logic [ADDR_W-1:0]   buf_addr,
    output logic [DATA_W-1:0]   buf_data
);

    logic full_r;

    assign ewb.full  = full_r;
    // held dirty line answers the cpu directly
    assign ewb.match = full_r && (buf_addr == req_addr);

    // occupancy
    always_ff @(posedge clk)
    begin
        if (rst)
            full_r <= 1'b0;
        else if (ewb.load)
            full_r <= 1'b1;
        else if (ewb.deq)
            full_r <= 1'b0;
    end

    // payload, cpu write on a match updates the held line
    always_ff @(posedge clk)
    begin
        if (ewb.load)
        begin
            buf_addr <= victim_addr;
            buf_data <= victim_data;
        end
        else if (mem_write && ewb.match)
            buf_data <= wdata;
    end

    // controller drains a full buffer before the next eviction
    assert property (@(posedge clk) disable iff (rst) !(ewb.load && full_r));

endmodule : eviction_buffer

// File: hw/cache_control.sv
`timescale 1ns/10ps

module cache_control #(
    parameter int DRAIN_DELAY = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_read,
    input  logic        mem_write,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    input  logic        pmem_resp,
    output logic        drain_sel,
    output logic        rdata_sel,
    cache_lookup_if.ctrl lk,
    cache_ewb_if.ctrl   ewb
);
    import cache_pkg::*;

    localparam int CNT_W = (DRAIN_DELAY > 0) ? $clog2(DRAIN_DELAY + 1) : 1;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        DRAIN
    } state_t;

    state_t state;
    state_t next_state;

    logic [CNT_W-1:0] cnt;
    logic             cnt_reload;
    logic             cnt_dec;

    // outputs and next state
    always_comb
    begin
        next_state = state;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        drain_sel  = 1'b0;
        rdata_sel  = 1'b0;
        lk.wr_src  = WR_NONE;
        lk.wr_way  = lk.victim_way;
        lk.fill    = 1'b0;
        lk.inval   = 1'b0;
        lk.plru_upd = 1'b0;
        ewb.load   = 1'b0;
        ewb.deq    = 1'b0;
        cnt_reload = 1'b0;
        cnt_dec    = 1'b0;

        case (state)
            IDLE:
            begin
                if (mem_read || mem_write)
                    next_state = LOOKUP;
                else if (ewb.full)
                begin
                    // idle countdown before write back
                    if (cnt == '0)
                        next_state = DRAIN;
                    else
                        cnt_dec = 1'b1;
                end
            end

            LOOKUP:
            begin
                cnt_reload = 1'b1;
                if (lk.hit)
                begin
                    mem_resp    = 1'b1;
                    lk.plru_upd = 1'b1;
                    lk.wr_way   = lk.hit_way;
                    if (mem_write)
                        lk.wr_src = WR_CPU;
                    next_state = IDLE;
                end
                else if (ewb.match)
                begin
                    // served by the buffer which also takes the write
                    mem_resp   = 1'b1;
                    rdata_sel  = 1'b1;
                    next_state = IDLE;
                end
                else if (!lk.victim_dirty)
                    next_state = FILL;
                // dirty victim with no room empties the buffer first
                else if (ewb.full)
                    next_state = DRAIN;
                else
                    next_state = EVICT;
            end

            EVICT:
            begin
                // victim moves to the buffer and its way is freed
                ewb.load   = 1'b1;
                lk.inval   = 1'b1;
                next_state = FILL;
            end

            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    lk.fill    = 1'b1;
                    lk.wr_src  = WR_MEM;
                    next_state = LOOKUP;
                end
            end

            DRAIN:
            begin
                cnt_reload = 1'b1;
                pmem_write = 1'b1;
                drain_sel  = 1'b1;
                if (pmem_resp)
                begin
                    ewb.deq    = 1'b1;
                    next_state = IDLE;
                end
            end

            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            cnt   <= CNT_W'(DRAIN_DELAY);
        end
        else
        begin
            state <= next_state;
            if (cnt_reload)
                cnt <= CNT_W'(DRAIN_DELAY);
            else if (cnt_dec)
                cnt <= cnt - 1'b1;
        end
    end

    // one memory command at a time
    assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

endmodule : cache_control

// File: hw/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
    parameter int ADDR_W      = 16,
    parameter int DATA_W      = 32,
    parameter int SET_BITS    = 3,
    parameter int DRAIN_DELAY = 3
) (
    input  logic                clk,
    input  logic                rst,
    // cpu side
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic [ADDR_W-1:0]   mem_addr,
    input  logic [DATA_W-1:0]   mem_wdata,
    output logic [DATA_W-1:0]   mem_rdata,
    output logic                mem_resp,
    // memory side
    output logic                pmem_read,
    output logic                pmem_write,
    output logic [ADDR_W-1:0]   pmem_addr,
    output logic [DATA_W-1:0]   pmem_wdata,
    input  logic [DATA_W-1:0]   pmem_rdata,
    input  logic                pmem_resp
);

    cache_lookup_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) lk ();
    cache_ewb_if ewb ();

    logic [ADDR_W-1:0] victim_addr;
    logic [DATA_W-1:0] victim_data;
    logic [ADDR_W-1:0] buf_addr;
    logic [DATA_W-1:0] buf_data;
    logic              drain_sel;
    logic              rdata_sel;
    logic              buf_wr;

    assign victim_addr = lk.victim_addr;
    assign victim_data = lk.victim_data;

    // freeze buffered data while it is on its way to memory
    assign buf_wr = mem_write && !drain_sel;

    cache_arrays #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .SET_BITS(SET_BITS)
    ) u_arrays (
        .clk(clk), .rst(rst), .addr(mem_addr), .wdata(mem_wdata),
        .fill_data(pmem_rdata), .lk(lk.arrays)
    );

    plru_tree #(.SET_BITS(SET_BITS)) u_plru (
        .clk(clk), .rst(rst), .set_idx(mem_addr[SET_BITS-1:0]), .lk(lk.repl)
    );

    eviction_buffer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_ewb (
        .clk(clk), .rst(rst), .ewb(ewb.buffer),
        .victim_addr(victim_addr), .victim_data(victim_data),
        .req_addr(mem_addr), .wdata(mem_wdata), .mem_write(buf_wr),
        .buf_addr(buf_addr), .buf_data(buf_data)
    );

    cache_control #(.DRAIN_DELAY(DRAIN_DELAY)) u_ctrl (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_resp(pmem_resp), .drain_sel(drain_sel), .rdata_sel(rdata_sel),
        .lk(lk.ctrl), .ewb(ewb.ctrl)
    );

    // cpu read data, buffer hit or cache way
    assign mem_rdata  = rdata_sel ? buf_data : lk.hit_data;
    // fill uses the cpu address, drain the buffered line
    assign pmem_addr  = drain_sel ? buf_addr : mem_addr;
    assign pmem_wdata = drain_sel ? buf_data : '0;

endmodule : cache_top

// File: sim/pmem_model.sv
`timescale 1ns/10ps

module pmem_model #(
    parameter int                ADDR_W  = 16,
    parameter int                DATA_W  = 32,
    parameter logic [DATA_W-1:0] RD_MASK = 32'hA5A5_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                pmem_read,
    input  logic                pmem_write,
    input  logic [ADDR_W-1:0]   pmem_addr,
    input  logic [DATA_W-1:0]   pmem_wdata,
    output logic [DATA_W-1:0]   pmem_rdata,
    output logic                pmem_resp,
    output int                  read_cnt,
    output int                  write_cnt
);

    // every written word, keyed by address
    logic [DATA_W-1:0] wr_log [logic [ADDR_W-1:0]];
    logic [15:0]       lfsr = 16'd15;
    logic              busy;
    int                wait_cnt;

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            busy       <= 1'b0;
            wait_cnt   <= 0;
            read_cnt   <= 0;
            write_cnt  <= 0;
        end
        // command still up on the answer edge, not a new one
        else if (pmem_resp)
            pmem_resp <= 1'b0;
        else if (!busy && (pmem_read || pmem_write))
        begin
            busy     <= 1'b1;
            // two bits, 1 to 4 cycles
            wait_cnt <= 1 + int'({lfsr_step(), lfsr_step()});
        end
        else if (busy)
        begin
            if (wait_cnt > 1)
                wait_cnt <= wait_cnt - 1;
            else
            begin
                busy      <= 1'b0;
                pmem_resp <= 1'b1;
                if (pmem_write)
                begin
                    wr_log[pmem_addr] = pmem_wdata;
                    write_cnt <= write_cnt + 1;
                end
                else
                begin
                    // unwritten words read as address xor mask
                    if (wr_log.exists(pmem_addr))
                        pmem_rdata <= wr_log[pmem_addr];
                    else
                        pmem_rdata <= DATA_W'(pmem_addr) ^ RD_MASK;
                    read_cnt <= read_cnt + 1;
                end
            end
        end
    end

endmodule : pmem_model

// File: sim/tb_cache.sv
`timescale 1ns/10ps

module tb_cache;
    import cache_pkg::*;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int SET_BITS   = 3;
    localparam int TAG_W      = ADDR_W - SET_BITS;
    localparam int NUM_SETS   = 1 << SET_BITS;
    localparam int CLK_PERIOD = 40;

    // row kinds
    localparam int OP_RD   = 0;
    localparam int OP_WR   = 1;
    localparam int OP_IDLE = 2;

    typedef struct {
        int                op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] rdata;
        int                mread;
    } row_t;

    logic              clk;
    logic              rst;
    logic              mem_read;
    logic              mem_write;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_resp;
    logic              pmem_read;
    logic              pmem_write;
    logic [ADDR_W-1:0] pmem_addr;
    logic [DATA_W-1:0] pmem_wdata;
    logic [DATA_W-1:0] pmem_rdata;
    logic              pmem_resp;
    int                read_cnt;
    int                write_cnt;
    int                errors;
    // write-backs predicted over the whole run
    int                wb_count;

    row_t rows[$];

    // reference model of the cache
    logic [TAG_W-1:0]    m_tag   [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0]   m_data  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
    logic [NUM_WAYS-1:0] m_dirty [NUM_SETS];
    plru_t               m_plru  [NUM_SETS];
    logic                m_full;
    logic [ADDR_W-1:0]   m_baddr;
    logic [DATA_W-1:0]   m_bdata;
    // predicted write-backs in order
    logic [ADDR_W-1:0]   exp_waddr[$];
    logic [DATA_W-1:0]   exp_wdata[$];

    cache_top dut0 (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_addr(pmem_addr), .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp)
    );

    pmem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem0 (
        .clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_addr(pmem_addr), .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp), .read_cnt(read_cnt), .write_cnt(write_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_way(input string name, input way_t got, input way_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // tree bits after a use of way w
    function automatic plru_t touch(plru_t p, way_t w);
        case (w)
            2'd0:    return {1'b0, 1'b0, p[0]};
            2'd1:    return {1'b0, 1'b1, p[0]};
            2'd2:    return {1'b1, p[1], 1'b0};
            default: return {1'b1, p[1], 1'b1};
        endcase
    endfunction

    // lowest invalid way or else from the half not used last
    function automatic way_t pick_victim(logic [NUM_WAYS-1:0] v, plru_t p);
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (!v[w])
                return way_t'(w);
        end
        if (!p[2])
            return p[0] ? 2'd2 : 2'd3;
        return p[1] ? 2'd0 : 2'd1;
    endfunction

    // buffered line heads for memory
    task automatic drain_model();
        if (m_full)
        begin
            exp_waddr.push_back(m_baddr);
            exp_wdata.push_back(m_bdata);
            wb_count++;
            m_full = 1'b0;
        end
    endtask

    // predicts the serving way
    // cached low means the buffer answers
    task automatic model_access(input row_t r, output logic cached, output way_t way);
        logic [SET_BITS-1:0] s;
        logic [TAG_W-1:0]    t;
        logic                hit;
        s      = r.addr[SET_BITS-1:0];
        t      = r.addr[ADDR_W-1:SET_BITS];
        hit    = 1'b0;
        way    = '0;
        cached = 1'b1;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (m_valid[s][w] && m_tag[s][w] == t)
            begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit && m_full && m_baddr == r.addr)
        begin
            cached = 1'b0;
            if (r.op == OP_WR)
                m_bdata = r.wdata;
        end
        else
        begin
            if (!hit)
            begin
                way = pick_victim(m_valid[s], m_plru[s]);
                // a full buffer drains before a dirty victim moves in
                if (m_valid[s][way] && m_dirty[s][way])
                begin
                    drain_model();
                    m_full  = 1'b1;
                    m_baddr = {m_tag[s][way], s};
                    m_bdata = m_data[s][way];
                end
                m_tag[s][way]   = t;
                m_valid[s][way] = 1'b1;
                m_dirty[s][way] = 1'b0;
                m_data[s][way]  = r.rdata;
            end
            if (r.op == OP_WR)
            begin
                m_data[s][way]  = r.wdata;
                m_dirty[s][way] = 1'b1;
            end
            m_plru[s] = touch(m_plru[s], way);
        end
    endtask

    task automatic add_row(input int op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rdata,
                           input int mread);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        r.rdata = rdata;
        r.mread = mread;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int   reads0;
        logic cached;
        way_t exp_way;
        if (r.op == OP_IDLE)
        begin
            // wait for the drain after the idle countdown
            drain_model();
            while (exp_waddr.size() != 0)
                @(negedge clk);
        end
        else
        begin
            model_access(r, cached, exp_way);
            reads0 = read_cnt;
            @(posedge clk);
            mem_read  <= (r.op == OP_RD);
            mem_write <= (r.op == OP_WR);
            mem_addr  <= r.addr;
            mem_wdata <= r.wdata;
            @(negedge clk);
            while (!mem_resp)
                @(negedge clk);
            if (r.op == OP_RD)
                check_data("mem_rdata", mem_rdata, r.rdata);
            if (cached)
                check_way("hit_way", dut0.lk.hit_way, exp_way);
            check_count("pmem reads", read_cnt - reads0, r.mread);
            @(posedge clk);
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
    endtask

    // every memory write against the prediction
    always @(negedge clk)
    begin
        if (!rst && pmem_write && pmem_resp)
        begin
            if (exp_waddr.size() == 0)
            begin
                errors++;
                $display("memory write to %h at %0t was not expected", pmem_addr, $time);
            end
            else
            begin
                check_addr("pmem_addr", pmem_addr, exp_waddr.pop_front());
                check_data("pmem_wdata", pmem_wdata, exp_wdata.pop_front());
            end
        end
    end

    initial
    begin
        #1;
        #(rows.size() * 40 * CLK_PERIOD);
        $display("watchdog expired, the cache stopped answering requests");
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        // read miss and hit then write hit and read back in set 2
        add_row(OP_RD, 16'h0102, 32'h0, 32'hA5A5_0102, 1);
        add_row(OP_RD, 16'h0102, 32'h0, 32'hA5A5_0102, 0);
        add_row(OP_WR, 16'h0102, 32'h5555_0102, 32'h0, 0);
        add_row(OP_RD, 16'h0102, 32'h0, 32'h5555_0102, 0);
        // four tags fill set 1
        add_row(OP_RD, 16'h0009, 32'h0, 32'hA5A5_0009, 1);
        add_row(OP_RD, 16'h0011, 32'h0, 32'hA5A5_0011, 1);
        add_row(OP_RD, 16'h0019, 32'h0, 32'hA5A5_0019, 1);
        add_row(OP_RD, 16'h0021, 32'h0, 32'hA5A5_0021, 1);
        // dirty all four as hits
        add_row(OP_WR, 16'h0009, 32'h1111_0009, 32'h0, 0);
        add_row(OP_WR, 16'h0011, 32'h2222_0011, 32'h0, 0);
        add_row(OP_WR, 16'h0019, 32'h3333_0019, 32'h0, 0);
        add_row(OP_WR, 16'h0021, 32'h4444_0021, 32'h0, 0);
        // access order leaves way 1 as victim
        add_row(OP_RD, 16'h0019, 32'h0, 32'h3333_0019, 0);
        add_row(OP_RD, 16'h0009, 32'h0, 32'h1111_0009, 0);
        add_row(OP_RD, 16'h0021, 32'h0, 32'h4444_0021, 0);
        add_row(OP_RD, 16'h0029, 32'h0, 32'hA5A5_0029, 1);
        // evicted line served and updated in the buffer
        add_row(OP_RD, 16'h0011, 32'h0, 32'h2222_0011, 0);
        add_row(OP_WR, 16'h0011, 32'h2B2B_0011, 32'h0, 0);
        add_row(OP_RD, 16'h0011, 32'h0, 32'h2B2B_0011, 0);
        add_row(OP_IDLE, '0, '0, '0, 0);
        // refetch of the drained line then a dirty miss on a full buffer
        add_row(OP_RD, 16'h0011, 32'h0, 32'h2B2B_0011, 1);
        add_row(OP_RD, 16'h0031, 32'h0, 32'hA5A5_0031, 1);
        add_row(OP_RD, 16'h0009, 32'h0, 32'h1111_0009, 0);
        add_row(OP_IDLE, '0, '0, '0, 0);

        errors    = 0;
        wb_count  = 0;
        rst       = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        m_full    = 1'b0;
        m_baddr   = '0;
        m_bdata   = '0;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_plru[s]  = '0;
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[i])
            apply_row(rows[i]);
        repeat (4) @(posedge clk);

        check_count("pmem writes", write_cnt, wb_count);
        if (exp_waddr.size() != 0)
        begin
            errors++;
            $display("%0d predicted memory writes never happened", exp_waddr.size());
        end
        $display("tb_cache finished with %0d errors", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule : tb_cache

// File: sim.f
hw/cache_pkg.sv
hw/cache_lookup_if.sv
hw/cache_ewb_if.sv
hw/cache_arrays.sv
hw/plru_tree.sv
hw/eviction_buffer.sv
hw/cache_control.sv
hw/cache_top.sv
sim/pmem_model.sv
sim/tb_cache.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache -f sim.f -o tb_cache_sim

./obj_dir/tb_cache_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
